/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                               clk,
  input  logic                               rst,
  input  pipe_pkg::if_id_type                if_id,
  input  logic                               reg_write,
  input  logic [rv_isa_pkg::REG_AW-1:0]      write_id,
  input  logic [rv_isa_pkg::XLEN-1:0]        write_data,
  output pipe_pkg::id_ex_type                id_ex_next
);

  logic [rv_isa_pkg::XLEN-1:0] regs [2 ** rv_isa_pkg::REG_AW];

  // Register read with x0 tied low and same-cycle write-through.
  function automatic logic [rv_isa_pkg::XLEN-1:0] read_reg(
    input logic [rv_isa_pkg::REG_AW-1:0] idx
  );
    if (idx == '0) begin
      return '0;
    end else if (reg_write && idx == write_id) begin
      return write_data;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2 ** rv_isa_pkg::REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write && write_id != '0) begin
      regs[write_id] <= write_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Decoder
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rv_isa_pkg::instruction_type instr;
    pipe_pkg::control_type       ctrl;
    logic [rv_isa_pkg::XLEN-1:0] imm_i;
    logic [rv_isa_pkg::XLEN-1:0] imm_s;
    logic [rv_isa_pkg::XLEN-1:0] imm_u;

    instr = if_id.instruction;
    imm_i = {{20{instr.funct7[6]}}, instr.funct7, instr.rs2};
    imm_s = {{20{instr.funct7[6]}}, instr.funct7, instr.rd};
    imm_u = {instr.funct7, instr.rs2, instr.rs1, instr.funct3, 12'b0};

    ctrl = '0;
    id_ex_next.imm = imm_i;
    case (instr.opcode)
      rv_isa_pkg::OP: begin
        ctrl.reg_write = 1'b1;
        case (instr.funct3)
          rv_isa_pkg::F3_ADD_SUB:
            ctrl.alu_op = (instr.funct7 == rv_isa_pkg::F7_SUB) ? rv_isa_pkg::ALU_SUB
                                                              : rv_isa_pkg::ALU_ADD;
          rv_isa_pkg::F3_SLT: ctrl.alu_op = rv_isa_pkg::ALU_SLT;
          rv_isa_pkg::F3_XOR: ctrl.alu_op = rv_isa_pkg::ALU_XOR;
          rv_isa_pkg::F3_OR:  ctrl.alu_op = rv_isa_pkg::ALU_OR;
          rv_isa_pkg::F3_AND: ctrl.alu_op = rv_isa_pkg::ALU_AND;
          default:            ctrl = '0;  // Shifts are not supported.
        endcase
      end
      rv_isa_pkg::OP_IMM: begin
        if (instr.funct3 == rv_isa_pkg::F3_ADD_SUB) begin  // ADDI only.
          ctrl.reg_write = 1'b1;
          ctrl.alu_src   = 1'b1;
        end
      end
      rv_isa_pkg::LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = rv_isa_pkg::ALU_PASS_B;
        id_ex_next.imm = imm_u;
      end
      rv_isa_pkg::LOAD: begin
        if (instr.funct3 == rv_isa_pkg::F3_WORD) begin
          ctrl.reg_write  = 1'b1;
          ctrl.mem_read   = 1'b1;
          ctrl.mem_to_reg = 1'b1;
          ctrl.alu_src    = 1'b1;
        end
      end
      rv_isa_pkg::STORE: begin
        if (instr.funct3 == rv_isa_pkg::F3_WORD) begin
          ctrl.mem_write = 1'b1;
          ctrl.alu_src   = 1'b1;
        end
        id_ex_next.imm = imm_s;
      end
      default: ctrl = '0;  // Unknown opcode is a bubble.
    endcase

    id_ex_next.control = ctrl;
    id_ex_next.data1   = read_reg(instr.rs1);
    id_ex_next.data2   = read_reg(instr.rs2);
    id_ex_next.rs1     = instr.rs1;
    id_ex_next.rs2     = instr.rs2;
    id_ex_next.rd      = instr.rd;
  end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  pipe_pkg::id_ex_type  id_ex,
  output pipe_pkg::ex_mem_type ex_mem_next
);

  logic [rv_isa_pkg::XLEN-1:0] op_a;
  logic [rv_isa_pkg::XLEN-1:0] op_b;
  logic [rv_isa_pkg::XLEN-1:0] alu_result;

  assign op_a = id_ex.data1;
  assign op_b = id_ex.control.alu_src ? id_ex.imm : id_ex.data2;

  // ~~~~~~~~~~~~~~~~~~~~
  // ALU
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (id_ex.control.alu_op)
      rv_isa_pkg::ALU_ADD:    alu_result = op_a + op_b;
      rv_isa_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv_isa_pkg::ALU_AND:    alu_result = op_a & op_b;
      rv_isa_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv_isa_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      rv_isa_pkg::ALU_SLT: begin
        alu_result = '0;
        alu_result[0] = $signed(op_a) < $signed(op_b);  // Signed compare.
      end
      rv_isa_pkg::ALU_PASS_B: alu_result = op_b;  // LUI.
      default:                alu_result = '0;
    endcase
  end

  always_comb begin
    ex_mem_next.control    = id_ex.control;
    ex_mem_next.rd         = id_ex.rd;
    ex_mem_next.store_data = id_ex.data2;  // Always rs2 for SW.
    ex_mem_next.alu_data   = alu_result;
    ex_mem_next.zero_flag  = (alu_result == '0);
  end

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                imem_we,
  input  logic [rv_isa_pkg::IMEM_AW-1:0]      imem_addr,
  input  logic [rv_isa_pkg::XLEN-1:0]         imem_data,
  output logic [rv_isa_pkg::XLEN-1:0]         pc,
  output rv_isa_pkg::instruction_type         instruction
);

  localparam int IMEM_WORDS = 2 ** rv_isa_pkg::IMEM_AW;

  logic [rv_isa_pkg::XLEN-1:0]    imem [IMEM_WORDS];
  logic [rv_isa_pkg::IMEM_AW-1:0] pc_word;

  // Empty words decode as bubbles.
  initial begin
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc + 4;  // No branches.
    end
  end

  assign pc_word     = pc[rv_isa_pkg::IMEM_AW+1:2];
  assign instruction = imem[pc_word];

endmodule

/* src/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  pipe_pkg::ex_mem_type ex_mem,
  output pipe_pkg::mem_wb_type mem_wb_next
);

  localparam int DMEM_WORDS = 2 ** rv_isa_pkg::DMEM_AW;

  logic [rv_isa_pkg::XLEN-1:0]    dmem [DMEM_WORDS];
  logic [rv_isa_pkg::DMEM_AW-1:0] word_addr;

  // Word addressed, low two bits ignored.
  assign word_addr = ex_mem.alu_data[rv_isa_pkg::DMEM_AW+1:2];

  always_ff @(posedge clk) begin
    if (!rst && ex_mem.control.mem_write) begin
      dmem[word_addr] <= ex_mem.store_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Read side
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    mem_wb_next.control = ex_mem.control;
    mem_wb_next.rd      = ex_mem.rd;
    mem_wb_next.bypass  = ex_mem.alu_data;
    if (ex_mem.control.mem_read) begin
      mem_wb_next.mem_output = dmem[word_addr];
    end else begin
      mem_wb_next.mem_output = '0;
    end
  end

endmodule

/* src/pipe_pkg.sv */
package pipe_pkg;

  typedef struct packed {
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic                alu_src;    // Operand B from the immediate.
    logic                mem_to_reg;
    rv_isa_pkg::alu_op_e alu_op;
  } control_type;

  // ~~~~~~~~~~~~~~~~~~~~
  // Stage registers
  // ~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] pc;
    rv_isa_pkg::instruction_type instruction;
  } if_id_type;

  typedef struct packed {
    control_type                   control;
    logic [rv_isa_pkg::XLEN-1:0]   data1;
    logic [rv_isa_pkg::XLEN-1:0]   data2;
    logic [rv_isa_pkg::XLEN-1:0]   imm;
    logic [rv_isa_pkg::REG_AW-1:0] rs1;
    logic [rv_isa_pkg::REG_AW-1:0] rs2;
    logic [rv_isa_pkg::REG_AW-1:0] rd;
  } id_ex_type;

  typedef struct packed {
    control_type                   control;
    logic [rv_isa_pkg::REG_AW-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]   store_data;
    logic [rv_isa_pkg::XLEN-1:0]   alu_data;
    logic                          zero_flag;
  } ex_mem_type;

  typedef struct packed {
    control_type                   control;
    logic [rv_isa_pkg::REG_AW-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]   mem_output;
    logic [rv_isa_pkg::XLEN-1:0]   bypass;
  } mem_wb_type;

endpackage

/* src/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               imem_we,
  input  logic [rv_isa_pkg::IMEM_AW-1:0]     imem_addr,
  input  logic [rv_isa_pkg::XLEN-1:0]        imem_data,
  output logic                               wb_valid,
  output logic [rv_isa_pkg::REG_AW-1:0]      wb_rd,
  output logic [rv_isa_pkg::XLEN-1:0]        wb_data
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Stage registers
  // ~~~~~~~~~~~~~~~~~~~~
  pipe_pkg::if_id_type  if_id;
  pipe_pkg::id_ex_type  id_ex;
  pipe_pkg::ex_mem_type ex_mem;
  pipe_pkg::mem_wb_type mem_wb;

  // Combinational stage results.
  pipe_pkg::if_id_type  if_id_next;
  pipe_pkg::id_ex_type  id_ex_next;
  pipe_pkg::ex_mem_type ex_mem_next;
  pipe_pkg::mem_wb_type mem_wb_next;

  logic [rv_isa_pkg::XLEN-1:0] fetch_pc;
  rv_isa_pkg::instruction_type fetch_instruction;
  logic [rv_isa_pkg::XLEN-1:0] write_data;

  assign if_id_next = '{pc: fetch_pc, instruction: fetch_instruction};

  always_ff @(posedge clk) begin
    if (rst) begin
      if_id  <= '0;
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end else begin
      if_id  <= if_id_next;
      id_ex  <= id_ex_next;
      ex_mem <= ex_mem_next;
      mem_wb <= mem_wb_next;
    end
  end

  // Writeback mux.
  assign write_data = mem_wb.control.mem_to_reg ? mem_wb.mem_output : mem_wb.bypass;

  assign wb_valid = mem_wb.control.reg_write && (mem_wb.rd != '0);
  assign wb_rd    = mem_wb.rd;
  assign wb_data  = write_data;

  // ~~~~~~~~~~~~~~~~~~~~
  // Stages
  // ~~~~~~~~~~~~~~~~~~~~
  fetch_stage u_fetch (
    .clk         (clk),
    .rst         (rst),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .pc          (fetch_pc),
    .instruction (fetch_instruction)
  );

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .if_id      (if_id),
    .reg_write  (mem_wb.control.reg_write),
    .write_id   (mem_wb.rd),
    .write_data (write_data),
    .id_ex_next (id_ex_next)
  );

  execute_stage u_execute (
    .id_ex       (id_ex),
    .ex_mem_next (ex_mem_next)
  );

  memory_stage u_memory (
    .clk         (clk),
    .rst         (rst),
    .ex_mem      (ex_mem),
    .mem_wb_next (mem_wb_next)
  );

endmodule

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int XLEN     = 32;
  localparam int REG_AW   = 5;
  localparam int IMEM_AW  = 8;   // Instruction memory words.
  localparam int DMEM_AW  = 8;   // Data memory words.
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;
  localparam int OPCODE_W = 7;

  // Funct codes for the supported subset.
  localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;
  localparam logic [FUNCT3_W-1:0] F3_WORD    = 3'b010;  // LW and SW.
  localparam logic [FUNCT7_W-1:0] F7_SUB     = 7'b0100000;

  // ~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [OPCODE_W-1:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // ADD sits at zero so an all-zero control word is a bubble.
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  // R-type field view; the other formats are sliced from the same bits.
  typedef struct packed {
    logic [FUNCT7_W-1:0] funct7;
    logic [REG_AW-1:0]   rs2;
    logic [REG_AW-1:0]   rs1;
    logic [FUNCT3_W-1:0] funct3;
    logic [REG_AW-1:0]   rd;
    opcode_e             opcode;
  } instruction_type;

endpackage

/* tests/rv_core_chk.sv */
`timescale 1ns/1ps

module rv_core_chk (
  input logic                          clk,
  input logic                          rst,
  input logic                          wb_valid,
  input logic [rv_isa_pkg::REG_AW-1:0] wb_rd,
  input logic [rv_isa_pkg::XLEN-1:0]   wb_data
);

  int fail_count = 0;  // Read by the testbench at the end.

  // Quiet during reset and on the first cycle after it.
  a_reset_quiet: assert property (@(posedge clk) rst |=> !wb_valid)
    else begin
      $error("Writeback seen during or right after reset");
      fail_count++;
    end

  a_rd_nonzero: assert property (@(posedge clk) wb_valid |-> wb_rd != '0)
    else begin
      $error("Writeback strobe raised for register x0");
      fail_count++;
    end

  a_data_known: assert property (@(posedge clk) wb_valid |-> !$isunknown(wb_data))
    else begin
      $error("Writeback data holds unknown bits");
      fail_count++;
    end

endmodule

/* tests/rv_core_monitor.sv */
`timescale 1ns/1ps

module rv_core_monitor (
  input  logic                          clk,
  input  logic                          wb_valid,
  input  logic [rv_isa_pkg::REG_AW-1:0] wb_rd,
  input  logic [rv_isa_pkg::XLEN-1:0]   wb_data,
  input  logic                          push,
  input  logic [rv_isa_pkg::REG_AW-1:0] push_rd,
  input  logic [rv_isa_pkg::XLEN-1:0]   push_data,
  output int                            pending,
  output int                            error_count
);

  typedef struct packed {
    logic [rv_isa_pkg::REG_AW-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]   data;
  } expect_type;

  expect_type expected [$];  // Program order.

  initial begin
    pending     = 0;
    error_count = 0;
  end

  always @(posedge clk) begin
    expect_type item;
    if (push) expected.push_back('{rd: push_rd, data: push_data});
    if (wb_valid) begin
      if (expected.size() == 0) begin
        $display("Writeback to x%0d arrived with no expectation left", wb_rd);
        error_count++;
      end else begin
        item = expected.pop_front();
        if (wb_rd !== item.rd) begin
          $display("Error: wb_rd expected 0x%02h got 0x%02h", item.rd, wb_rd);
          error_count++;
        end
        if (wb_data !== item.data) begin
          $display("Error: wb_data expected 0x%08h got 0x%08h (x%0d)",
                   item.data, wb_data, item.rd);
          error_count++;
        end
      end
    end
    pending = expected.size();
  end

  task automatic check_drained();
    if (expected.size() != 0) begin
      $display("%0d expected writebacks never appeared", expected.size());
      error_count++;
    end
  endtask

endmodule

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

  localparam int N_ROWS         = 21;
  localparam int RESET_CYCLES   = 8;
  localparam int WB_CYCLES      = N_ROWS + 4;  // Last fetch plus the pipeline depth.
  localparam int DRAIN_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = N_ROWS + 20;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef struct packed {
    logic [31:0] encoding;
    logic [4:0]  rd;
    logic [31:0] value;
    logic        writes;
  } row_type;

  row_type                        rows [N_ROWS];
  logic                           clk = 1'b0;
  logic                           rst;
  logic                           imem_we;
  logic                           wb_valid;
  logic                           push;
  logic [rv_isa_pkg::IMEM_AW-1:0] imem_addr;
  logic [rv_isa_pkg::XLEN-1:0]    imem_data;
  logic [rv_isa_pkg::XLEN-1:0]    wb_data;
  logic [rv_isa_pkg::XLEN-1:0]    push_data;
  logic [rv_isa_pkg::REG_AW-1:0]  wb_rd;
  logic [rv_isa_pkg::REG_AW-1:0]  push_rd;
  int                             pending;
  int                             error_count;
  int                             total_errors;
  int                             cycle;
  int                             waited;

  // ~~~~~~~~~~~~~~~~~~~~
  // Encoders
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OPC_IMM};
  endfunction

  function automatic logic [31:0] lw_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, OPC_LOAD};
  endfunction

  function automatic logic [31:0] sw_word(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  // Two slots between each producer and its consumer.
  task automatic fill_program();
    rows[0]  = '{addi_word(1, 0, 12'd5), 5'd1, 32'h0000_0005, 1'b1};
    rows[1]  = '{addi_word(2, 0, 12'hffd), 5'd2, 32'hffff_fffd, 1'b1};  // -3.
    rows[2]  = '{lui_word(3, 20'h12345), 5'd3, 32'h1234_5000, 1'b1};
    rows[3]  = '{addi_word(4, 0, 12'h7ff), 5'd4, 32'h0000_07ff, 1'b1};
    rows[4]  = '{r_type_word(7'h00, 3'b000, 5, 1, 2), 5'd5, 32'h0000_0002, 1'b1};  // ADD.
    rows[5]  = '{r_type_word(7'h20, 3'b000, 6, 1, 2), 5'd6, 32'h0000_0008, 1'b1};  // SUB.
    rows[6]  = '{r_type_word(7'h00, 3'b111, 7, 1, 4), 5'd7, 32'h0000_0005, 1'b1};  // AND.
    rows[7]  = '{r_type_word(7'h00, 3'b110, 8, 2, 3), 5'd8, 32'hffff_fffd, 1'b1};  // OR.
    rows[8]  = '{r_type_word(7'h00, 3'b100, 9, 1, 3), 5'd9, 32'h1234_5005, 1'b1};  // XOR.
    rows[9]  = '{r_type_word(7'h00, 3'b010, 10, 2, 1), 5'd10, 32'h0000_0001, 1'b1};  // -3 < 5.
    rows[10] = '{r_type_word(7'h00, 3'b010, 11, 1, 2), 5'd11, 32'h0000_0000, 1'b1};
    rows[11] = '{addi_word(0, 1, 12'd7), 5'd0, 32'h0, 1'b0};  // Write to x0 is dropped.
    rows[12] = '{sw_word(3, 0, 12'd8), 5'd0, 32'h0, 1'b0};
    rows[13] = '{32'h0000_0000, 5'd0, 32'h0, 1'b0};
    rows[14] = '{addi_word(12, 0, 12'd9), 5'd12, 32'h0000_0009, 1'b1};  // x0 still 0.
    rows[15] = '{lw_word(13, 0, 12'd8), 5'd13, 32'h1234_5000, 1'b1};
    rows[16] = '{32'h0000_0fff, 5'd0, 32'h0, 1'b0};  // Unknown opcode.
    rows[17] = '{addi_word(15, 0, 12'h800), 5'd15, 32'hffff_f800, 1'b1};
    rows[18] = '{r_type_word(7'h00, 3'b000, 14, 13, 12), 5'd14, 32'h1234_5009, 1'b1};
    rows[19] = '{r_type_word(7'h20, 3'b000, 16, 12, 13), 5'd16, 32'hedcb_b009, 1'b1};
    rows[20] = '{lui_word(17, 20'hfffff), 5'd17, 32'hffff_f000, 1'b1};
  endtask

  rv_core u_dut (.clk(clk), .rst(rst), .imem_we(imem_we), .imem_addr(imem_addr),
                 .imem_data(imem_data), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data));

  rv_core_monitor u_mon (.clk(clk), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
                         .push(push), .push_rd(push_rd), .push_data(push_data),
                         .pending(pending), .error_count(error_count));

  bind rv_core rv_core_chk u_chk (.clk(clk), .rst(rst), .wb_valid(wb_valid),
                                  .wb_rd(wb_rd), .wb_data(wb_data));

  initial begin
    forever #4 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Main flow
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin
    rst = 1'b1;
    imem_we = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    push = 1'b0;
    push_rd = '0;
    push_data = '0;
    fill_program();
    for (int i = 0; i < N_ROWS; i++) begin  // Load while the core is held in reset.
      @(posedge clk);
      #1;
      imem_we = 1'b1;
      imem_addr = i;
      imem_data = rows[i].encoding;
      push = rows[i].writes;
      push_rd = rows[i].rd;
      push_data = rows[i].value;
    end
    @(posedge clk);
    #1;
    imem_we = 1'b0;
    push = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    waited = 0;
    while (pending != 0 && waited < WB_CYCLES) begin
      @(posedge clk);
      #1;
      waited++;
    end
    repeat (DRAIN_CYCLES) @(posedge clk);  // Catch stray writebacks.
    #1;
    u_mon.check_drained();
    #1;
    total_errors = error_count + u_dut.u_chk.fail_count;
    $display("Closing: %0d monitor errors, %0d assertion failures",
             error_count, u_dut.u_chk.fail_count);
    if (total_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    @(negedge rst);
    for (cycle = 0; cycle < TIMEOUT_CYCLES; cycle++) begin
      @(posedge clk);
    end
    $display("Timeout after %0d cycles with %0d writebacks still missing",
             TIMEOUT_CYCLES, pending);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* vlog.f */
src/rv_isa_pkg.sv
src/pipe_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/rv_core.sv
tests/rv_core_chk.sv
tests/rv_core_monitor.sv
tests/rv_core_tb.sv
